// File: Bender.yml
package:
  name: uart_wb

sources:
  - uart_pkg.sv
  - uart_bus_if.sv
  - uart_wb.sv
  - uart_regs.sv
  - uart_tx.sv
  - uart_rx.sv
  - uart_top.sv
  - target: test
    files:
      - uart_checker.sv
      - tb_uart.sv

// File: build.f
uart_pkg.sv
uart_bus_if.sv
uart_wb.sv
uart_regs.sv
uart_tx.sv
uart_rx.sv
uart_top.sv
uart_checker.sv
tb_uart.sv

// File: tb_uart.sv
// UART testbench
// Replays the golden file on the WISHBONE bus and on srx

`timescale 1ns/1ps

module tb_uart;

	localparam int ACK_TIMEOUT = 50;

	logic                                 clk;
	logic                                 wb_rst_i;
	logic                                 wb_cyc_i;
	logic                                 wb_stb_i;
	logic                                 wb_we_i;
	logic [3:0]                           wb_sel_i;
	logic [uart_pkg::UART_ADDR_WIDTH-1:0] wb_adr_i;
	logic [31:0]                          wb_dat_i;
	logic [31:0]                          wb_dat_o;
	logic                                 wb_ack_o;
	logic                                 srx_i;
	logic                                 stx_o;

	int          seed;
	int          bit_clks;
	logic [7:0]  lcr;
	logic [15:0] divisor;
	int          tb_err;
	int          rd_ops;
	int          tx_ops;
	int          chk_err;
	int          chk_rd;
	int          chk_tx;

	uart_top #(
		.LITTLE_ENDIAN (1'b1),
		.DIV_RESET     (16'd16)
	) UUT (
		.clk      (clk),
		.wb_rst_i (wb_rst_i),
		.wb_cyc_i (wb_cyc_i),
		.wb_stb_i (wb_stb_i),
		.wb_we_i  (wb_we_i),
		.wb_sel_i (wb_sel_i),
		.wb_adr_i (wb_adr_i),
		.wb_dat_i (wb_dat_i),
		.wb_dat_o (wb_dat_o),
		.wb_ack_o (wb_ack_o),
		.srx_i    (srx_i),
		.stx_o    (stx_o)
	);

	uart_checker u_chk (
		.clk         (clk),
		.wb_rst_i    (wb_rst_i),
		.ack_i       (wb_ack_o),
		.we_i        (wb_we_i),
		.dat_i       (wb_dat_o),
		.stx_i       (stx_o),
		.bit_clks_i  (bit_clks),
		.err_count_o (chk_err),
		.rd_count_o  (chk_rd),
		.tx_count_o  (chk_tx)
	);

	// 8 ns period
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic report_and_finish();
		$display("reads %0d of %0d, frames %0d of %0d, errors %0d",
			chk_rd, rd_ops, chk_tx, tx_ops, chk_err + tb_err);
		if (chk_err + tb_err == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	endtask

	// One-hot select to lane number
	function automatic logic [1:0] sel_lane(input logic [3:0] sel);
		case (sel)
			4'b0010: return 2'd1;
			4'b0100: return 2'd2;
			4'b1000: return 2'd3;
			default: return 2'd0;
		endcase
	endfunction

	// Follow LCR and divisor writes for the serial bit time
	task automatic track_write(input logic [4:0] adr, input logic [3:0] sel,
			input logic [31:0] dat);
		logic [1:0] lane;
		logic [4:0] off;
		logic [7:0] b;
		lane = sel_lane(sel);
		off  = {adr[4:2], lane};
		b    = dat[8*lane +: 8];
		if (off == uart_pkg::REG_LCR)
			lcr = b;
		else if (off == uart_pkg::REG_RB_THR && lcr[uart_pkg::LCR_DLAB])
			divisor[7:0] = b;
		else if (off == uart_pkg::REG_DLM && lcr[uart_pkg::LCR_DLAB])
			divisor[15:8] = b;
		bit_clks = 16 * divisor;
	endtask

	// Strobe held one edge past ack so the checker sees we with it
	task automatic bus_cycle(input logic we, input logic [4:0] adr, input logic [3:0] sel,
			input logic [31:0] dat);
		int cnt;
		bit seen;
		cnt  = 0;
		seen = 1'b0;
		@(posedge clk);
		#1;
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_we_i  = we;
		wb_adr_i = adr;
		wb_sel_i = sel;
		wb_dat_i = dat;
		while (!seen && cnt < ACK_TIMEOUT) begin
			@(posedge clk);
			#1;
			seen = wb_ack_o;
			cnt++;
		end
		@(posedge clk);
		#1;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i  = 1'b0;
		if (!seen) begin
			$display("timeout waiting for wb_ack_o at address %h", adr);
			tb_err++;
			report_and_finish();
		end
	endtask

	// Start, data LSB first, stop at the given level
	task automatic drive_frame(input logic [7:0] b, input logic stop);
		logic [9:0] bits;
		int         i;
		bits = {stop, b, 1'b0};
		@(posedge clk);
		#1;
		for (i = 0; i < 10; i++) begin
			srx_i = bits[i];
			repeat (bit_clks) @(posedge clk);
			#1;
		end
		srx_i = 1'b1;
	endtask

	task automatic wait_frames(input int n);
		int cnt;
		cnt = 0;
		while (chk_tx < n && cnt < 20 * bit_clks) begin
			@(posedge clk);
			cnt++;
		end
		if (chk_tx < n) begin
			$display("timeout waiting for a frame on stx_o");
			tb_err++;
			report_and_finish();
		end
	endtask

	task automatic idle_gap();
		int gap;
		gap = $unsigned($random(seed)) % 8;
		repeat (gap) @(posedge clk);
	endtask

	initial begin : main
		int          fd;
		int          n;
		string       line;
		string       name;
		byte         op;
		logic [7:0]  adr_f;
		logic [3:0]  sel_f;
		logic [31:0] dat_f;
		seed     = 32'h764c_c283;
		lcr      = 8'h03;
		divisor  = 16'd16;
		bit_clks = 256;
		tb_err   = 0;
		rd_ops   = 0;
		tx_ops   = 0;
		wb_rst_i = 1'b1;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i  = 1'b0;
		wb_sel_i = 4'h0;
		wb_adr_i = '0;
		wb_dat_i = 32'h0;
		srx_i    = 1'b1;
		repeat (8) @(posedge clk);
		#1;
		wb_rst_i = 1'b0;
		fd = $fopen("uart_golden.txt", "r");
		if (fd == 0) begin
			$display("cannot open uart_golden.txt");
			tb_err++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n    = $fgets(line, fd);
				if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
					n = $sscanf(line, "%c %s %h %h %h", op, name, adr_f, sel_f, dat_f);
					if (n != 5) begin
						$display("malformed line in golden file: %s", line);
						tb_err++;
					end else begin
						case (op)
							"W": begin
								track_write(adr_f[4:0], sel_f, dat_f);
								bus_cycle(1'b1, adr_f[4:0], sel_f, dat_f);
							end
							"R": begin
								rd_ops++;
								bus_cycle(1'b0, adr_f[4:0], sel_f, 32'h0);
							end
							"S": drive_frame(dat_f[7:0], sel_f[0]);
							"T": begin
								tx_ops++;
								wait_frames(tx_ops);
							end
							default: begin
								$display("unknown operation in golden file: %s", line);
								tb_err++;
							end
						endcase
						idle_gap();
					end
				end
			end
			$fclose(fd);
		end
		// Last read compare lands on the edge after its ack
		repeat (4) @(posedge clk);
		if (chk_rd != rd_ops) begin
			$display("checker compared %0d reads but %0d were issued", chk_rd, rd_ops);
			tb_err++;
		end
		if (chk_tx != tx_ops) begin
			$display("checker decoded %0d frames but %0d were expected", chk_tx, tx_ops);
			tb_err++;
		end
		report_and_finish();
	end

endmodule

// File: uart_bus_if.sv
// Internal register access bus
// Byte-wide path from the WISHBONE slave into the register block

`timescale 1ns/1ps

interface uart_bus_if;
	// Single-cycle strobes
	logic we;
	logic re;
	// Internal byte address
	logic [uart_pkg::UART_ADDR_WIDTH-1:0] adr;
	logic [7:0] wdat;
	// Read data, combinational from adr
	logic [7:0] rdat;
	// Debug word
	logic [31:0] dbg;

	modport wb (output we, output re, output adr, output wdat, input rdat, input dbg);
	modport regs (input we, input re, input adr, input wdat, output rdat, output dbg);
endinterface

// File: uart_checker.sv
// UART response checker
// Compares bus reads and decoded stx frames with the golden file

`timescale 1ns/1ps

module uart_checker (
	input  logic        clk,
	input  logic        wb_rst_i,
	input  logic        ack_i,
	input  logic        we_i,
	input  logic [31:0] dat_i,
	input  logic        stx_i,
	input  int          bit_clks_i,
	output int          err_count_o,
	output int          rd_count_o,
	output int          tx_count_o
);

	// Expected entries in file order
	string       rd_name[$];
	logic [31:0] rd_exp[$];
	string       tx_name[$];
	logic [7:0]  tx_exp[$];
	int          rd_err;
	int          tx_err;

	assign err_count_o = rd_err + tx_err;

	//////////////////////////////////////////////////
	// Bus reads
	//////////////////////////////////////////////////

	// wb_dat_o is held for the whole ack cycle
	always @(posedge clk) begin
		if (!wb_rst_i && ack_i && !we_i) begin
			if (rd_count_o >= rd_exp.size()) begin
				$display("unexpected read acknowledge with data %h", dat_i);
				rd_err <= rd_err + 1;
			end else if (dat_i !== rd_exp[rd_count_o]) begin
				$display("[ERROR] %s: expected %h, actual %h",
					rd_name[rd_count_o], rd_exp[rd_count_o], dat_i);
				rd_err <= rd_err + 1;
			end
			rd_count_o <= rd_count_o + 1;
		end
	end

	//////////////////////////////////////////////////
	// Golden file and stx decoder
	//////////////////////////////////////////////////

	initial begin : frame_decode
		int          fd;
		int          n;
		int          cnt;
		int          i;
		string       line;
		string       name;
		byte         op;
		logic [7:0]  adr_f;
		logic [3:0]  sel_f;
		logic [31:0] dat_f;
		logic [7:0]  data;
		logic        stop;
		logic        prev;
		fd = $fopen("uart_golden.txt", "r");
		if (fd == 0) begin
			$display("checker cannot open uart_golden.txt");
			tx_err++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n    = $fgets(line, fd);
				if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
					n = $sscanf(line, "%c %s %h %h %h", op, name, adr_f, sel_f, dat_f);
					// Only reads and transmit frames carry expected values
					if (n == 5 && op == "R") begin
						rd_name.push_back(name);
						rd_exp.push_back(dat_f);
					end else if (n == 5 && op == "T") begin
						tx_name.push_back(name);
						tx_exp.push_back(dat_f[7:0]);
					end
				end
			end
			$fclose(fd);
		end
		cnt = 0;
		while (wb_rst_i !== 1'b0 && cnt < 1000) begin
			@(posedge clk);
			cnt++;
		end
		if (wb_rst_i !== 1'b0) begin
			$display("reset was never released");
			tx_err++;
		end
		if (stx_i !== 1'b1) begin
			$display("stx_o is not idle high after reset");
			tx_err++;
		end
		prev = stx_i;
		forever begin
			@(posedge clk);
			// Falling edge starts a frame
			if (prev === 1'b1 && stx_i === 1'b0) begin
				repeat (bit_clks_i / 2) @(posedge clk);
				if (stx_i !== 1'b0) begin
					$display("start bit on stx_o is shorter than half a bit");
					tx_err++;
				end else begin
					// Data LSB first, mid-bit samples
					for (i = 0; i < 8; i++) begin
						repeat (bit_clks_i) @(posedge clk);
						data[i] = stx_i;
					end
					repeat (bit_clks_i) @(posedge clk);
					stop = stx_i;
					// Rest of the stop bit so TEMT is back
					repeat (bit_clks_i / 2 + 4) @(posedge clk);
					if (tx_count_o >= tx_exp.size()) begin
						$display("unexpected frame on stx_o with data %h", data);
						tx_err++;
					end else if (data !== tx_exp[tx_count_o]) begin
						$display("[ERROR] %s: expected %h, actual %h",
							tx_name[tx_count_o], tx_exp[tx_count_o], data);
						tx_err++;
					end
					if (stop !== 1'b1) begin
						$display("stop bit on stx_o is low");
						tx_err++;
					end
					tx_count_o++;
				end
			end
			prev = stx_i;
		end
	end

endmodule

// File: uart_golden.txt
# op name adr sel data, all hex; W write, R read with data as expected word
# S drive byte on srx with sel as stop bit level, T expected byte on stx
R lsr_reset 04 2 00006000
W lcr_dlab 00 8 83000000
W dll_wr 00 1 00000004
W dlm_wr 00 2 00000100
R dll_rd 00 1 00000004
R dlm_rd 00 2 00000100
R dbg_word 00 f 01048360
W dlm_clr 00 2 00000000
W lcr_8n1 00 8 03000000
W scr_wr 04 8 a5000000
R scr_lane3 04 8 a5000000
W off4_wr 04 1 5a5a5a5a
R off4_lane0 04 1 00000000
R lsr_lane1 04 2 00006000
R off6_lane2 04 4 00000000
R scr_keep 04 8 a5000000
W thr_wr 00 1 000000a7
T tx_frame 00 0 000000a7
R lsr_tx_done 04 2 00006000
S rx_byte 00 1 0000005c
R lsr_dr 04 2 00006100
R rbr_rd 00 1 0000005c
R lsr_dr_clr 04 2 00006000
S rx_first 00 1 00000011
S rx_second 00 1 00000022
R lsr_oe 04 2 00006300
R rbr_oe 00 1 00000022
R lsr_oe_clr 04 2 00006000
S rx_bad_stop 00 0 00000033
R lsr_fe 04 2 00006900
R lsr_fe_clr 04 2 00006100
R rbr_fe 00 1 00000033
R lsr_final 04 2 00006000

// File: uart_pkg.sv
// UART shared definitions
// Register map, status bit positions and the 32-bit bus word view

package uart_pkg;

	//////////////////////////////////////////////////
	// Register space
	//////////////////////////////////////////////////

	// Byte address width, low two bits come from wb_sel_i
	localparam int UART_ADDR_WIDTH = 5;

	// Internal byte offsets
	// Offset 0 is DLL while DLAB is set, RBR/THR otherwise
	localparam logic [UART_ADDR_WIDTH-1:0] REG_RB_THR = 5'd0;
	localparam logic [UART_ADDR_WIDTH-1:0] REG_DLM    = 5'd1;
	localparam logic [UART_ADDR_WIDTH-1:0] REG_LCR    = 5'd3;
	localparam logic [UART_ADDR_WIDTH-1:0] REG_LSR    = 5'd5;
	localparam logic [UART_ADDR_WIDTH-1:0] REG_SCR    = 5'd7;

	// Line status bits
	localparam int LSR_DR   = 0;
	localparam int LSR_OE   = 1;
	localparam int LSR_FE   = 3;
	localparam int LSR_THRE = 5;
	localparam int LSR_TEMT = 6;

	// Divisor latch access bit in LCR
	localparam int LCR_DLAB = 7;

	//////////////////////////////////////////////////
	// Bus word
	//////////////////////////////////////////////////

	// Whole word for debug reads, four lanes for byte access
	// Debug word: [31:16] divisor {DLM,DLL}, [15:8] LCR, [7:0] LSR
	typedef union packed {
		logic [31:0]     word;
		logic [3:0][7:0] lane;
	} wb_word_u;

endpackage

// File: uart_regs.sv
// UART register block
// Divisor latch and baud tick, LCR, SCR, holding registers and LSR

`timescale 1ns/1ps

module uart_regs #(
	parameter logic [15:0] DIV_RESET = 16'd16
) (
	input  logic        clk,
	input  logic        wb_rst_i,
	uart_bus_if.regs    bus,
	output logic        tx_req_o,
	output logic [7:0]  tx_dat_o,
	input  logic        tx_ack_i,
	input  logic        tx_busy_i,
	input  logic        rx_valid_i,
	input  logic [7:0]  rx_dat_i,
	input  logic        rx_ferr_i,
	output logic        baud_tick_o
);

	logic [uart_pkg::UART_ADDR_WIDTH-1:0] adr;
	logic [7:0]  dll;
	logic [7:0]  dlm;
	logic [7:0]  lcr;
	logic [7:0]  scr;
	logic [7:0]  rbr;
	logic [7:0]  lsr;
	logic        dlab;
	logic        dr;
	logic        oe;
	logic        fe;
	logic        thre;
	logic        temt;
	logic        wr_thr;
	logic        rd_rbr;
	logic        rd_lsr;
	logic [15:0] divisor;
	logic [15:0] baud_cnt;

	assign adr  = bus.adr;
	assign dlab = lcr[uart_pkg::LCR_DLAB];

	// Decoded accesses
	assign wr_thr = bus.we & (adr == uart_pkg::REG_RB_THR) & ~dlab & thre;
	assign rd_rbr = bus.re & (adr == uart_pkg::REG_RB_THR) & ~dlab;
	assign rd_lsr = bus.re & (adr == uart_pkg::REG_LSR);

	//////////////////////////////////////////////////
	// Configuration
	//////////////////////////////////////////////////

	// LCR resets to 8N1 and only its DLAB bit acts
	always_ff @(posedge clk or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			dll <= DIV_RESET[7:0];
			dlm <= DIV_RESET[15:8];
			lcr <= 8'h03;
		end else if (bus.we) begin
			if (adr == uart_pkg::REG_RB_THR && dlab)
				dll <= bus.wdat;
			if (adr == uart_pkg::REG_DLM && dlab)
				dlm <= bus.wdat;
			if (adr == uart_pkg::REG_LCR)
				lcr <= bus.wdat;
		end
	end

	// Scratch and holding bytes
	always_ff @(posedge clk) begin
		if (bus.we && adr == uart_pkg::REG_SCR)
			scr <= bus.wdat;
		if (wr_thr)
			tx_dat_o <= bus.wdat;
		// Overrun keeps the newest byte
		if (rx_valid_i)
			rbr <= rx_dat_i;
	end

	//////////////////////////////////////////////////
	// TX handshake and line status
	//////////////////////////////////////////////////

	// Req drops once the transmitter has taken the byte
	always_ff @(posedge clk or posedge wb_rst_i) begin
		if (wb_rst_i)
			tx_req_o <= 1'b0;
		else if (wr_thr)
			tx_req_o <= 1'b1;
		else if (tx_ack_i)
			tx_req_o <= 1'b0;
	end

	// New data wins over a clearing read
	always_ff @(posedge clk or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			dr <= 1'b0;
			oe <= 1'b0;
			fe <= 1'b0;
		end else begin
			if (rx_valid_i)
				dr <= 1'b1;
			else if (rd_rbr)
				dr <= 1'b0;
			if (rx_valid_i && dr)
				oe <= 1'b1;
			else if (rd_lsr)
				oe <= 1'b0;
			if (rx_valid_i && rx_ferr_i)
				fe <= 1'b1;
			else if (rd_lsr)
				fe <= 1'b0;
		end
	end

	// Holding register busy for the whole handshake
	assign thre = ~(tx_req_o | tx_ack_i);
	assign temt = thre & ~tx_busy_i;

	always_comb begin
		lsr                     = 8'h00;
		lsr[uart_pkg::LSR_DR]   = dr;
		lsr[uart_pkg::LSR_OE]   = oe;
		lsr[uart_pkg::LSR_FE]   = fe;
		lsr[uart_pkg::LSR_THRE] = thre;
		lsr[uart_pkg::LSR_TEMT] = temt;
	end

	// Unmapped offsets read zero
	always_comb begin
		bus.rdat = 8'h00;
		case (adr)
			uart_pkg::REG_RB_THR: bus.rdat = dlab ? dll : rbr;
			uart_pkg::REG_DLM:    bus.rdat = dlab ? dlm : 8'h00;
			uart_pkg::REG_LCR:    bus.rdat = lcr;
			uart_pkg::REG_LSR:    bus.rdat = lsr;
			uart_pkg::REG_SCR:    bus.rdat = scr;
			default:              bus.rdat = 8'h00;
		endcase
	end

	assign bus.dbg = {dlm, dll, lcr, lsr};

	//////////////////////////////////////////////////
	// Baud tick
	//////////////////////////////////////////////////

	assign divisor = {dlm, dll};

	// One pulse every divisor clocks and none for divisor zero
	always_ff @(posedge clk or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			baud_cnt    <= 16'h0;
			baud_tick_o <= 1'b0;
		end else if (divisor == 16'h0) begin
			baud_cnt    <= 16'h0;
			baud_tick_o <= 1'b0;
		end else if (baud_cnt >= divisor - 16'd1) begin
			baud_cnt    <= 16'h0;
			baud_tick_o <= 1'b1;
		end else begin
			baud_cnt    <= baud_cnt + 16'd1;
			baud_tick_o <= 1'b0;
		end
	end

	// Byte offered to the transmitter must not move
	a_tx_dat_stable: assert property (@(posedge clk) disable iff (wb_rst_i)
		tx_req_o |=> !tx_req_o || $stable(tx_dat_o));

endmodule

// File: uart_rx.sv
// UART receiver
// Synchronises srx, confirms the start bit at mid-bit, samples
// 8 data bits and checks the stop bit

`timescale 1ns/1ps

module uart_rx (
	input  logic       clk,
	input  logic       wb_rst_i,
	input  logic       baud_tick_i,
	input  logic       srx_i,
	output logic       rx_valid_o,
	output logic [7:0] rx_dat_o,
	output logic       rx_ferr_o
);

	localparam logic [1:0] RX_IDLE  = 2'd0;
	localparam logic [1:0] RX_START = 2'd1;
	localparam logic [1:0] RX_DATA  = 2'd2;
	localparam logic [1:0] RX_STOP  = 2'd3;

	logic       srx_s1;
	logic       srx_s2;
	logic       srx_prev;
	logic       fall;
	logic [1:0] state;
	logic [3:0] tick_cnt;
	logic [2:0] bit_cnt;
	logic       sample_bit;
	logic [7:0] shreg;

	assign fall       = srx_prev & ~srx_s2;
	// Middle of a data bit
	assign sample_bit = (state == RX_DATA) & baud_tick_i & (tick_cnt == 4'd15);
	assign rx_dat_o   = shreg;

	// Data bits arrive LSB first
	always_ff @(posedge clk) begin
		if (sample_bit)
			shreg <= {srx_s2, shreg[7:1]};
	end

	always_ff @(posedge clk or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			srx_s1     <= 1'b1;
			srx_s2     <= 1'b1;
			srx_prev   <= 1'b1;
			state      <= RX_IDLE;
			tick_cnt   <= 4'd0;
			bit_cnt    <= 3'd0;
			rx_valid_o <= 1'b0;
			rx_ferr_o  <= 1'b0;
		end else begin
			// Two-flop synchroniser plus edge history
			srx_s1     <= srx_i;
			srx_s2     <= srx_s1;
			srx_prev   <= srx_s2;
			rx_valid_o <= 1'b0;
			case (state)
				RX_IDLE: begin
					if (fall) begin
						state    <= RX_START;
						tick_cnt <= 4'd0;
					end
				end
				RX_START: begin
					if (baud_tick_i) begin
						if (tick_cnt == 4'd7) begin
							// Glitch shorter than half a bit is ignored
							tick_cnt <= 4'd0;
							bit_cnt  <= 3'd0;
							state    <= srx_s2 ? RX_IDLE : RX_DATA;
						end else begin
							tick_cnt <= tick_cnt + 4'd1;
						end
					end
				end
				RX_DATA: begin
					if (baud_tick_i)
						tick_cnt <= tick_cnt + 4'd1;
					if (sample_bit) begin
						bit_cnt <= bit_cnt + 3'd1;
						if (bit_cnt == 3'd7)
							state <= RX_STOP;
					end
				end
				default: begin
					if (baud_tick_i) begin
						tick_cnt <= tick_cnt + 4'd1;
						if (tick_cnt == 4'd15) begin
							// Low stop bit is a framing error
							rx_valid_o <= 1'b1;
							rx_ferr_o  <= ~srx_s2;
							state      <= RX_IDLE;
						end
					end
				end
			endcase
		end
	end

endmodule

// File: uart_top.sv
// UART top level
// WISHBONE slave, register block, transmitter and receiver

`timescale 1ns/1ps

module uart_top #(
	parameter bit          LITTLE_ENDIAN = 1'b1,
	parameter logic [15:0] DIV_RESET     = 16'd16
) (
	input  logic                                 clk,
	input  logic                                 wb_rst_i,
	input  logic                                 wb_cyc_i,
	input  logic                                 wb_stb_i,
	input  logic                                 wb_we_i,
	input  logic [3:0]                           wb_sel_i,
	input  logic [uart_pkg::UART_ADDR_WIDTH-1:0] wb_adr_i,
	input  logic [31:0]                          wb_dat_i,
	output logic [31:0]                          wb_dat_o,
	output logic                                 wb_ack_o,
	input  logic                                 srx_i,
	output logic                                 stx_o
);

	// TX handshake
	logic       tx_req;
	logic [7:0] tx_dat;
	logic       tx_ack;
	logic       tx_busy;
	// RX handover
	logic       rx_valid;
	logic [7:0] rx_dat;
	logic       rx_ferr;
	// Sixteen per bit
	logic       baud_tick;

	uart_bus_if bus_if ();

	uart_wb #(
		.LITTLE_ENDIAN (LITTLE_ENDIAN)
	) u_wb (
		.clk      (clk),
		.wb_rst_i (wb_rst_i),
		.wb_cyc_i (wb_cyc_i),
		.wb_stb_i (wb_stb_i),
		.wb_we_i  (wb_we_i),
		.wb_sel_i (wb_sel_i),
		.wb_adr_i (wb_adr_i),
		.wb_dat_i (wb_dat_i),
		.wb_dat_o (wb_dat_o),
		.wb_ack_o (wb_ack_o),
		.bus      (bus_if.wb)
	);

	uart_regs #(
		.DIV_RESET (DIV_RESET)
	) u_regs (
		.clk         (clk),
		.wb_rst_i    (wb_rst_i),
		.bus         (bus_if.regs),
		.tx_req_o    (tx_req),
		.tx_dat_o    (tx_dat),
		.tx_ack_i    (tx_ack),
		.tx_busy_i   (tx_busy),
		.rx_valid_i  (rx_valid),
		.rx_dat_i    (rx_dat),
		.rx_ferr_i   (rx_ferr),
		.baud_tick_o (baud_tick)
	);

	uart_tx u_tx (
		.clk         (clk),
		.wb_rst_i    (wb_rst_i),
		.baud_tick_i (baud_tick),
		.tx_req_i    (tx_req),
		.tx_dat_i    (tx_dat),
		.tx_ack_o    (tx_ack),
		.tx_busy_o   (tx_busy),
		.stx_o       (stx_o)
	);

	uart_rx u_rx (
		.clk         (clk),
		.wb_rst_i    (wb_rst_i),
		.baud_tick_i (baud_tick),
		.srx_i       (srx_i),
		.rx_valid_o  (rx_valid),
		.rx_dat_o    (rx_dat),
		.rx_ferr_o   (rx_ferr)
	);

endmodule

// File: uart_tx.sv
// UART transmitter
// Takes a byte by req/ack and shifts out one 8N1 frame

`timescale 1ns/1ps

module uart_tx (
	input  logic       clk,
	input  logic       wb_rst_i,
	input  logic       baud_tick_i,
	input  logic       tx_req_i,
	input  logic [7:0] tx_dat_i,
	output logic       tx_ack_o,
	output logic       tx_busy_o,
	output logic       stx_o
);

	logic [9:0] frame;
	logic       sending;
	logic       accept;
	logic       bit_end;
	logic       shift_en;
	logic [3:0] tick_cnt;
	logic [3:0] bit_cnt;

	// Idle and previous ack already gone
	assign accept   = tx_req_i & ~tx_ack_o & ~tx_busy_o;
	// Sixteenth tick of a bit
	assign bit_end  = sending & baud_tick_i & (tick_cnt == 4'd15);
	assign shift_en = bit_end & (bit_cnt != 4'd9);

	// Ack side of the handshake
	always_ff @(posedge clk or posedge wb_rst_i) begin
		if (wb_rst_i)
			tx_ack_o <= 1'b0;
		else if (accept)
			tx_ack_o <= 1'b1;
		else if (!tx_req_i)
			tx_ack_o <= 1'b0;
	end

	// Stop, data LSB first, start
	always_ff @(posedge clk) begin
		if (accept)
			frame <= {1'b1, tx_dat_i, 1'b0};
		else if (shift_en)
			frame <= {1'b1, frame[9:1]};
	end

	// Busy from byte capture to the end of the stop bit
	always_ff @(posedge clk or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			tx_busy_o <= 1'b0;
			sending   <= 1'b0;
			tick_cnt  <= 4'd0;
			bit_cnt   <= 4'd0;
			stx_o     <= 1'b1;
		end else if (accept) begin
			tx_busy_o <= 1'b1;
		end else if (tx_busy_o && baud_tick_i) begin
			if (!sending) begin
				// Frame starts on the first tick after capture
				sending  <= 1'b1;
				tick_cnt <= 4'd0;
				bit_cnt  <= 4'd0;
				stx_o    <= frame[0];
			end else if (bit_end) begin
				tick_cnt <= 4'd0;
				if (bit_cnt == 4'd9) begin
					tx_busy_o <= 1'b0;
					sending   <= 1'b0;
					stx_o     <= 1'b1;
				end else begin
					bit_cnt <= bit_cnt + 4'd1;
					stx_o   <= frame[1];
				end
			end else begin
				tick_cnt <= tick_cnt + 4'd1;
			end
		end
	end

	// Line idles high between frames
	a_idle_high: assert property (@(posedge clk) disable iff (wb_rst_i)
		!tx_busy_o |-> stx_o);

endmodule

// File: uart_wb.sv
// UART WISHBONE slave
// Samples the bus, inserts one wait state and maps byte lanes
// onto the internal 8-bit register bus

`timescale 1ns/1ps

module uart_wb #(
	parameter bit LITTLE_ENDIAN = 1'b1
) (
	input  logic                                 clk,
	input  logic                                 wb_rst_i,
	input  logic                                 wb_cyc_i,
	input  logic                                 wb_stb_i,
	input  logic                                 wb_we_i,
	input  logic [3:0]                           wb_sel_i,
	input  logic [uart_pkg::UART_ADDR_WIDTH-1:0] wb_adr_i,
	input  logic [31:0]                          wb_dat_i,
	output logic [31:0]                          wb_dat_o,
	output logic                                 wb_ack_o,
	uart_bus_if.wb                               bus
);

	// Ack machine states
	localparam logic [1:0] ST_IDLE  = 2'd0;
	localparam logic [1:0] ST_WAIT1 = 2'd1;
	localparam logic [1:0] ST_WAIT2 = 2'd2;

	// Sampled bus
	logic                                 cyc_is;
	logic                                 stb_is;
	logic                                 we_is;
	logic [3:0]                           sel_is;
	logic [uart_pkg::UART_ADDR_WIDTH-1:0] adr_is;
	uart_pkg::wb_word_u                   dat_is;

	logic [1:0]         state;
	logic               access;
	logic [1:0]         lane_idx;
	logic               lane_ok;
	logic [1:0]         adr_lsb;
	uart_pkg::wb_word_u rd_word;

	//////////////////////////////////////////////////
	// Input sampling
	//////////////////////////////////////////////////

	always_ff @(posedge clk or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			cyc_is <= 1'b0;
			stb_is <= 1'b0;
			we_is  <= 1'b0;
		end else begin
			cyc_is <= wb_cyc_i;
			stb_is <= wb_stb_i;
			we_is  <= wb_we_i;
		end
	end

	// Address, select and data ride along with the strobe
	always_ff @(posedge clk) begin
		sel_is      <= wb_sel_i;
		adr_is      <= wb_adr_i;
		dat_is.word <= wb_dat_i;
	end

	//////////////////////////////////////////////////
	// Acknowledge machine
	//////////////////////////////////////////////////

	// Only the idle state may start an access
	assign access = stb_is & cyc_is & (state == ST_IDLE);

	// Ack and the internal strobe share one cycle before two blocked states
	always_ff @(posedge clk or posedge wb_rst_i) begin
		if (wb_rst_i) begin
			state    <= ST_IDLE;
			wb_ack_o <= 1'b0;
			bus.we   <= 1'b0;
			bus.re   <= 1'b0;
		end else begin
			wb_ack_o <= access;
			bus.we   <= access & we_is;
			bus.re   <= access & ~we_is;
			case (state)
				ST_IDLE:  state <= access ? ST_WAIT1 : ST_IDLE;
				ST_WAIT1: state <= ST_WAIT2;
				default:  state <= ST_IDLE;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Byte lane steering
	//////////////////////////////////////////////////

	// One-hot select to lane number
	always_comb begin
		lane_ok = 1'b1;
		case (sel_is)
			4'b0001: lane_idx = 2'd0;
			4'b0010: lane_idx = 2'd1;
			4'b0100: lane_idx = 2'd2;
			4'b1000: lane_idx = 2'd3;
			default: begin
				lane_idx = 2'd0;
				lane_ok  = 1'b0;
			end
		endcase
	end

	// Big endian reverses the lane to offset order
	assign adr_lsb  = LITTLE_ENDIAN ? lane_idx : ~lane_idx;
	assign bus.adr  = {adr_is[uart_pkg::UART_ADDR_WIDTH-1:2], adr_lsb};
	assign bus.wdat = dat_is.lane[lane_idx];

	// Full select returns the debug view instead of a lane
	always_comb begin
		rd_word.word = 32'h0;
		if (sel_is == 4'b1111)
			rd_word.word = bus.dbg;
		else if (lane_ok)
			rd_word.lane[lane_idx] = bus.rdat;
	end

	// Captured on the ack edge and held while ack is high
	always_ff @(posedge clk) begin
		if (access & ~we_is)
			wb_dat_o <= rd_word.word;
	end

	// Internal strobes are exclusive
	a_we_re_excl: assert property (@(posedge clk) disable iff (wb_rst_i)
		!(bus.we && bus.re));

endmodule
